//--- source/bus_pkg.sv
package bus_pkg;

  localparam int ADDR_W     = 32;
  localparam int DATA_W     = 32;
  localparam int AXI_DATA_W = 64;

  // clint mtime, low and high word
  localparam logic [ADDR_W-1:0] MTIME_LO_ADDR = 32'h0200_bff8;
  localparam logic [ADDR_W-1:0] MTIME_HI_ADDR = 32'h0200_bffc;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [3:0]        wstrb;
    logic              we;
  } bus_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] rdata;
    logic              err;
  } bus_rsp_t;

  typedef enum logic [0:0] {
    OWNER_IFU = 1'b0,
    OWNER_LSU = 1'b1
  } owner_t;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [7:0]        len;
    logic [2:0]        size;
    logic [1:0]        burst;
    logic [3:0]        id;
  } axi_ar_t;

  // same layout as ar
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [7:0]        len;
    logic [2:0]        size;
    logic [1:0]        burst;
    logic [3:0]        id;
  } axi_aw_t;

  typedef struct packed {
    logic [AXI_DATA_W-1:0]   data;
    logic [AXI_DATA_W/8-1:0] strb;
    logic                    last;
  } axi_w_t;

  typedef struct packed {
    logic [AXI_DATA_W-1:0] data;
    logic [1:0]            resp;
    logic                  last;
  } axi_r_t;

  typedef struct packed {
    logic [1:0] resp;
  } axi_b_t;

endpackage

//--- source/bus_req_arbiter.sv
module bus_req_arbiter (
  input  logic              clk,
  input  logic              rst,
  input  bus_pkg::bus_req_t ifu_req_i,
  input  logic              ifu_req_valid_i,
  output logic              ifu_req_ready_o,
  input  bus_pkg::bus_req_t lsu_req_i,
  input  logic              lsu_req_valid_i,
  output logic              lsu_req_ready_o,
  input  logic              rsp_done_i,
  output bus_pkg::bus_req_t cur_req_o,
  output logic              cur_valid_o,
  output bus_pkg::owner_t   cur_owner_o,
  output logic              cur_local_o
);
  import bus_pkg::*;

  typedef enum logic [1:0] {
    ST_INIT,
    ST_IDLE,
    ST_BUSY
  } state_t;

  state_t   state;
  bus_req_t req_q;
  owner_t   owner_q;
  logic     local_q;
  logic     lsu_fire;
  logic     ifu_fire;
  logic     grant;
  bus_req_t win_req;

  assign lsu_req_ready_o = (state == ST_IDLE);
  assign ifu_req_ready_o = (state == ST_IDLE) && !lsu_req_valid_i; // lsu first

  assign lsu_fire = lsu_req_valid_i && lsu_req_ready_o;
  assign ifu_fire = ifu_req_valid_i && ifu_req_ready_o;
  assign grant    = lsu_fire || ifu_fire;
  assign win_req  = lsu_fire ? lsu_req_i : ifu_req_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_INIT;
    end else begin
      case (state)
        ST_INIT: state <= ST_IDLE; // readies stay low one cycle
        ST_IDLE: begin
          if (grant) begin
            state <= ST_BUSY;
          end
        end
        ST_BUSY: begin
          if (rsp_done_i) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // latch winner and decide timer routing at capture
  always_ff @(posedge clk) begin
    if (grant) begin
      req_q   <= win_req;
      owner_q <= lsu_fire ? OWNER_LSU : OWNER_IFU;
      local_q <= !win_req.we &&
                 (win_req.addr == MTIME_LO_ADDR || win_req.addr == MTIME_HI_ADDR);
    end
  end

  assign cur_req_o   = req_q;
  assign cur_valid_o = (state == ST_BUSY);
  assign cur_owner_o = owner_q;
  assign cur_local_o = local_q;

endmodule

//--- source/axi_master_port.sv
module axi_master_port (
  input  logic                       clk,
  input  logic                       rst,
  input  bus_pkg::bus_req_t          cur_req_i,
  input  logic                       cur_start_i,
  output bus_pkg::axi_ar_t           ar_o,
  output logic                       arvalid_o,
  input  logic                       arready_i,
  input  bus_pkg::axi_r_t            r_i,
  input  logic                       rvalid_i,
  output logic                       rready_o,
  output bus_pkg::axi_aw_t           aw_o,
  output logic                       awvalid_o,
  input  logic                       awready_i,
  output bus_pkg::axi_w_t            w_o,
  output logic                       wvalid_o,
  input  logic                       wready_i,
  input  bus_pkg::axi_b_t            b_i,
  input  logic                       bvalid_i,
  output logic                       bready_o,
  output logic                       done_o,
  output logic [bus_pkg::DATA_W-1:0] rdata_o,
  output logic                       err_o
);
  import bus_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_READ,
    ST_WRITE,
    ST_DONE
  } state_t;

  state_t     state;
  logic       ar_acc;
  logic       aw_acc;
  logic       w_acc;
  logic       lane_hi;
  logic [2:0] size;
  logic       rd_done;
  logic       wr_done;

  // bytes in strobe -> axsize
  function automatic logic [2:0] strb_size(input logic [3:0] strb);
    case ($countones(strb))
      1:       strb_size = 3'd0;
      2:       strb_size = 3'd1;
      default: strb_size = 3'd2;
    endcase
  endfunction

  assign lane_hi = cur_req_i.addr[2]; // upper half of the 64-bit beat
  assign size    = strb_size(cur_req_i.wstrb);

  // single beat, incr, id 0
  assign ar_o = '{addr: cur_req_i.addr, len: 8'd0, size: size, burst: 2'b01, id: 4'd0};
  assign aw_o = '{addr: cur_req_i.addr, len: 8'd0, size: size, burst: 2'b01, id: 4'd0};

  assign w_o.data = lane_hi ? {cur_req_i.wdata, {DATA_W{1'b0}}}
                            : {{DATA_W{1'b0}}, cur_req_i.wdata};
  assign w_o.strb = lane_hi ? {cur_req_i.wstrb, 4'b0} : {4'b0, cur_req_i.wstrb};
  assign w_o.last = 1'b1;

  assign arvalid_o = (state == ST_READ) && !ar_acc;
  assign awvalid_o = (state == ST_WRITE) && !aw_acc;
  assign wvalid_o  = (state == ST_WRITE) && !w_acc;
  assign rready_o  = 1'b1;
  assign bready_o  = 1'b1;

  assign rd_done = (state == ST_READ) && rvalid_i;
  assign wr_done = (state == ST_WRITE) && bvalid_i;
  assign done_o  = rd_done || wr_done;
  assign rdata_o = lane_hi ? r_i.data[AXI_DATA_W-1:DATA_W] : r_i.data[DATA_W-1:0];
  assign err_o   = rd_done ? (r_i.resp != 2'b00) : (b_i.resp != 2'b00);

  always_ff @(posedge clk) begin
    if (rst) begin
      state  <= ST_IDLE;
      ar_acc <= 1'b0;
      aw_acc <= 1'b0;
      w_acc  <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          ar_acc <= 1'b0;
          aw_acc <= 1'b0;
          w_acc  <= 1'b0;
          if (cur_start_i) begin
            state <= cur_req_i.we ? ST_WRITE : ST_READ;
          end
        end
        ST_READ: begin
          if (arvalid_o && arready_i) begin
            ar_acc <= 1'b1;
          end
          if (rvalid_i) begin
            state <= ST_DONE;
          end
        end
        ST_WRITE: begin
          // aw and w drop on their own handshakes
          if (awvalid_o && awready_i) begin
            aw_acc <= 1'b1;
          end
          if (wvalid_o && wready_i) begin
            w_acc <= 1'b1;
          end
          if (bvalid_i) begin
            state <= ST_DONE;
          end
        end
        ST_DONE: begin
          if (!cur_start_i) begin
            state <= ST_IDLE; // arbiter has released the request
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule

//--- source/clint_timer.sv
module clint_timer (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       rd_en_i,
  input  logic [bus_pkg::ADDR_W-1:0] addr_i,
  output logic                       rvalid_o,
  output logic [bus_pkg::DATA_W-1:0] rdata_o
);
  import bus_pkg::*;

  logic [63:0] mtime;

  always_ff @(posedge clk) begin
    if (rst) begin
      mtime    <= '0;
      rvalid_o <= 1'b0;
    end else begin
      mtime    <= mtime + 64'd1; // free running
      rvalid_o <= rd_en_i;
    end
  end

  // word select on the read pulse
  always_ff @(posedge clk) begin
    if (rd_en_i) begin
      rdata_o <= (addr_i == MTIME_HI_ADDR) ? mtime[63:32] : mtime[31:0];
    end
  end

endmodule

//--- source/bus_rsp_router.sv
module bus_rsp_router (
  input  logic                       clk,
  input  logic                       rst,
  input  bus_pkg::owner_t            owner_i,
  input  logic                       axi_done_i,
  input  logic [bus_pkg::DATA_W-1:0] axi_rdata_i,
  input  logic                       axi_err_i,
  input  logic                       tmr_valid_i,
  input  logic [bus_pkg::DATA_W-1:0] tmr_rdata_i,
  output bus_pkg::bus_rsp_t          ifu_rsp_o,
  output logic                       ifu_rsp_valid_o,
  output bus_pkg::bus_rsp_t          lsu_rsp_o,
  output logic                       lsu_rsp_valid_o,
  output logic                       rsp_done_o
);
  import bus_pkg::*;

  bus_rsp_t rsp_q;
  logic     ifu_vld_q;
  logic     lsu_vld_q;
  logic     fin;

  assign fin = axi_done_i || tmr_valid_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      ifu_vld_q <= 1'b0;
      lsu_vld_q <= 1'b0;
    end else begin
      ifu_vld_q <= fin && (owner_i == OWNER_IFU);
      lsu_vld_q <= fin && (owner_i == OWNER_LSU);
    end
  end

  always_ff @(posedge clk) begin
    if (axi_done_i) begin
      rsp_q <= '{rdata: axi_rdata_i, err: axi_err_i};
    end else if (tmr_valid_i) begin
      rsp_q <= '{rdata: tmr_rdata_i, err: 1'b0}; // timer never errors
    end
  end

  // shared payload, valid picks the client
  assign ifu_rsp_o       = rsp_q;
  assign lsu_rsp_o       = rsp_q;
  assign ifu_rsp_valid_o = ifu_vld_q;
  assign lsu_rsp_valid_o = lsu_vld_q;
  assign rsp_done_o      = ifu_vld_q || lsu_vld_q;

endmodule

//--- source/core_bus.sv
module core_bus (
  input  logic              clk,
  input  logic              rst,
  input  bus_pkg::bus_req_t ifu_req_i,
  input  logic              ifu_req_valid_i,
  output logic              ifu_req_ready_o,
  output bus_pkg::bus_rsp_t ifu_rsp_o,
  output logic              ifu_rsp_valid_o,
  input  bus_pkg::bus_req_t lsu_req_i,
  input  logic              lsu_req_valid_i,
  output logic              lsu_req_ready_o,
  output bus_pkg::bus_rsp_t lsu_rsp_o,
  output logic              lsu_rsp_valid_o,
  output bus_pkg::axi_ar_t  ar_o,
  output logic              arvalid_o,
  input  logic              arready_i,
  input  bus_pkg::axi_r_t   r_i,
  input  logic              rvalid_i,
  output logic              rready_o,
  output bus_pkg::axi_aw_t  aw_o,
  output logic              awvalid_o,
  input  logic              awready_i,
  output bus_pkg::axi_w_t   w_o,
  output logic              wvalid_o,
  input  logic              wready_i,
  input  bus_pkg::axi_b_t   b_i,
  input  logic              bvalid_i,
  output logic              bready_o
);
  import bus_pkg::*;

  bus_req_t          cur_req;
  logic              cur_valid;
  owner_t            cur_owner;
  logic              cur_local;
  logic              axi_start;
  logic              axi_done;
  logic [DATA_W-1:0] axi_rdata;
  logic              axi_err;
  logic              tmr_rd_en;
  logic              tmr_armed;
  logic              tmr_valid;
  logic [DATA_W-1:0] tmr_rdata;
  logic              rsp_done;

  assign axi_start = cur_valid && !cur_local;
  // disarmed from the timer answer until the arbiter goes idle
  assign tmr_armed = !tmr_valid && !rsp_done;
  assign tmr_rd_en = cur_valid && cur_local && tmr_armed;

  bus_req_arbiter u_arbiter (
    .clk             (clk),
    .rst             (rst),
    .ifu_req_i       (ifu_req_i),
    .ifu_req_valid_i (ifu_req_valid_i),
    .ifu_req_ready_o (ifu_req_ready_o),
    .lsu_req_i       (lsu_req_i),
    .lsu_req_valid_i (lsu_req_valid_i),
    .lsu_req_ready_o (lsu_req_ready_o),
    .rsp_done_i      (rsp_done),
    .cur_req_o       (cur_req),
    .cur_valid_o     (cur_valid),
    .cur_owner_o     (cur_owner),
    .cur_local_o     (cur_local)
  );

  axi_master_port u_axi_port (
    .clk         (clk),
    .rst         (rst),
    .cur_req_i   (cur_req),
    .cur_start_i (axi_start),
    .ar_o        (ar_o),
    .arvalid_o   (arvalid_o),
    .arready_i   (arready_i),
    .r_i         (r_i),
    .rvalid_i    (rvalid_i),
    .rready_o    (rready_o),
    .aw_o        (aw_o),
    .awvalid_o   (awvalid_o),
    .awready_i   (awready_i),
    .w_o         (w_o),
    .wvalid_o    (wvalid_o),
    .wready_i    (wready_i),
    .b_i         (b_i),
    .bvalid_i    (bvalid_i),
    .bready_o    (bready_o),
    .done_o      (axi_done),
    .rdata_o     (axi_rdata),
    .err_o       (axi_err)
  );

  clint_timer u_timer (
    .clk      (clk),
    .rst      (rst),
    .rd_en_i  (tmr_rd_en),
    .addr_i   (cur_req.addr),
    .rvalid_o (tmr_valid),
    .rdata_o  (tmr_rdata)
  );

  bus_rsp_router u_router (
    .clk             (clk),
    .rst             (rst),
    .owner_i         (cur_owner),
    .axi_done_i      (axi_done),
    .axi_rdata_i     (axi_rdata),
    .axi_err_i       (axi_err),
    .tmr_valid_i     (tmr_valid),
    .tmr_rdata_i     (tmr_rdata),
    .ifu_rsp_o       (ifu_rsp_o),
    .ifu_rsp_valid_o (ifu_rsp_valid_o),
    .lsu_rsp_o       (lsu_rsp_o),
    .lsu_rsp_valid_o (lsu_rsp_valid_o),
    .rsp_done_o      (rsp_done)
  );

endmodule

//--- tb/axi_mem_model.sv
module ready_delay (
  input  logic clk,
  input  logic rst,
  input  logic valid_i,
  output logic ready_o
);
  logic [1:0] cnt;

  assign ready_o = valid_i && (cnt == 2'd0);

  always @(posedge clk) begin
    if (rst) begin
      cnt <= 2'd0;
    end else if (ready_o) begin
      cnt <= 2'($urandom % 4); // stall before the next beat
    end else if (valid_i && cnt != 2'd0) begin
      cnt <= cnt - 2'd1;
    end
  end
endmodule

module axi_mem_model (
  input  logic              clk,
  input  logic              rst,
  input  bus_pkg::axi_ar_t  ar_i,
  input  logic              arvalid_i,
  output logic              arready_o,
  output bus_pkg::axi_r_t   r_o,
  output logic              rvalid_o,
  input  bus_pkg::axi_aw_t  aw_i,
  input  logic              awvalid_i,
  output logic              awready_o,
  input  bus_pkg::axi_w_t   w_i,
  input  logic              wvalid_i,
  output logic              wready_o,
  output bus_pkg::axi_b_t   b_o,
  output logic              bvalid_o,
  output int                txn_cnt_o,
  output int                size_err_o
);
  import bus_pkg::*;

  localparam logic [31:0] ERR_BASE = 32'h8000_0000;

  logic [7:0] mem [0:1023];
  axi_aw_t    aw_q;
  axi_w_t     w_q;
  logic       aw_got;
  logic       w_got;
  logic       ar_hs;
  logic       aw_hs;
  logic       w_hs;

  function automatic logic [2:0] size_rule(input logic [7:0] strb);
    case ($countones(strb))
      1:       size_rule = 3'd0;
      2:       size_rule = 3'd1;
      default: size_rule = 3'd2;
    endcase
  endfunction

  ready_delay u_ar_dly (.clk(clk), .rst(rst), .valid_i(arvalid_i), .ready_o(arready_o));
  ready_delay u_aw_dly (.clk(clk), .rst(rst), .valid_i(awvalid_i), .ready_o(awready_o));
  ready_delay u_w_dly  (.clk(clk), .rst(rst), .valid_i(wvalid_i),  .ready_o(wready_o));

  assign ar_hs = arvalid_i && arready_o;
  assign aw_hs = awvalid_i && awready_o;
  assign w_hs  = wvalid_i && wready_o;

  always @(posedge clk) begin
    if (rst) begin
      rvalid_o   <= 1'b0;
      bvalid_o   <= 1'b0;
      aw_got     <= 1'b0;
      w_got      <= 1'b0;
      txn_cnt_o  <= 0;
      size_err_o <= 0;
      for (int i = 0; i < 1024; i++) begin
        mem[i] <= 8'h00;
      end
    end else begin
      rvalid_o <= ar_hs;
      bvalid_o <= 1'b0;
      if (ar_hs) begin
        txn_cnt_o <= txn_cnt_o + 1;
        r_o.last  <= 1'b1;
        if (ar_i.addr >= ERR_BASE) begin
          r_o.data <= '0;
          r_o.resp <= 2'b10; // slverr
        end else begin
          for (int i = 0; i < 8; i++) begin
            r_o.data[8*i +: 8] <= mem[{ar_i.addr[9:3], i[2:0]}];
          end
          r_o.resp <= 2'b00;
        end
      end
      if (aw_hs) begin
        aw_q      <= aw_i;
        aw_got    <= 1'b1;
        txn_cnt_o <= txn_cnt_o + 1;
      end
      if (w_hs) begin
        w_q   <= w_i;
        w_got <= 1'b1;
      end
      // commit and answer once both halves are in
      if (aw_got && w_got) begin
        aw_got   <= 1'b0;
        w_got    <= 1'b0;
        bvalid_o <= 1'b1;
        b_o.resp <= (aw_q.addr >= ERR_BASE) ? 2'b10 : 2'b00;
        if (aw_q.size != size_rule(w_q.strb)) begin
          size_err_o <= size_err_o + 1;
        end
        if (aw_q.addr < ERR_BASE) begin
          for (int i = 0; i < 8; i++) begin
            if (w_q.strb[i]) begin
              mem[{aw_q.addr[9:3], i[2:0]}] <= w_q.data[8*i +: 8];
            end
          end
        end
      end
    end
  end

endmodule

//--- tb/tb_core_bus.sv
module tb_core_bus;
  import bus_pkg::*;

  localparam int MAX_CASES = 64;

  logic     clk = 1'b0;
  logic     rst;
  bus_req_t ifu_req;
  bus_req_t lsu_req;
  logic     ifu_req_valid;
  logic     lsu_req_valid;
  logic     ifu_req_ready;
  logic     lsu_req_ready;
  bus_rsp_t ifu_rsp;
  bus_rsp_t lsu_rsp;
  logic     ifu_rsp_valid;
  logic     lsu_rsp_valid;
  axi_ar_t  ar;
  axi_aw_t  aw;
  axi_w_t   w;
  axi_r_t   r;
  axi_b_t   b;
  logic     arvalid;
  logic     arready;
  logic     rvalid;
  logic     rready;
  logic     awvalid;
  logic     awready;
  logic     wvalid;
  logic     wready;
  logic     bvalid;
  logic     bready;
  int       txn_cnt;
  int       size_errs;

  int          errors = 0;
  int          n_cases = 0;
  int          ifu_pending = 0;
  int          lsu_pending = 0;
  logic        loaded = 1'b0;
  bus_rsp_t    ifu_q[$];
  bus_rsp_t    lsu_q[$];
  logic [31:0] c_port [0:MAX_CASES-1];
  logic [31:0] c_we [0:MAX_CASES-1];
  logic [31:0] c_addr [0:MAX_CASES-1];
  logic [31:0] c_wdata [0:MAX_CASES-1];
  logic [31:0] c_wstrb [0:MAX_CASES-1];
  logic [31:0] c_rdata [0:MAX_CASES-1];
  logic [31:0] c_err [0:MAX_CASES-1];
  logic [7:0]  ref_mem [0:1023];
  logic [31:0] last_mtime = 32'd0;

  always #20 clk = ~clk;

  core_bus u_core_bus (
    .clk(clk), .rst(rst),
    .ifu_req_i(ifu_req), .ifu_req_valid_i(ifu_req_valid), .ifu_req_ready_o(ifu_req_ready),
    .ifu_rsp_o(ifu_rsp), .ifu_rsp_valid_o(ifu_rsp_valid),
    .lsu_req_i(lsu_req), .lsu_req_valid_i(lsu_req_valid), .lsu_req_ready_o(lsu_req_ready),
    .lsu_rsp_o(lsu_rsp), .lsu_rsp_valid_o(lsu_rsp_valid),
    .ar_o(ar), .arvalid_o(arvalid), .arready_i(arready),
    .r_i(r), .rvalid_i(rvalid), .rready_o(rready),
    .aw_o(aw), .awvalid_o(awvalid), .awready_i(awready),
    .w_o(w), .wvalid_o(wvalid), .wready_i(wready),
    .b_i(b), .bvalid_i(bvalid), .bready_o(bready)
  );

  axi_mem_model u_mem (
    .clk(clk), .rst(rst),
    .ar_i(ar), .arvalid_i(arvalid), .arready_o(arready), .r_o(r), .rvalid_o(rvalid),
    .aw_i(aw), .awvalid_i(awvalid), .awready_o(awready),
    .w_i(w), .wvalid_i(wvalid), .wready_o(wready), .b_o(b), .bvalid_o(bvalid),
    .txn_cnt_o(txn_cnt), .size_err_o(size_errs)
  );

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    errors++;
    $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
  endtask

  function automatic logic [31:0] ref_read(input logic [31:0] a);
    ref_read = {ref_mem[{a[9:2], 2'd3}], ref_mem[{a[9:2], 2'd2}],
                ref_mem[{a[9:2], 2'd1}], ref_mem[{a[9:2], 2'd0}]};
  endfunction

  task automatic ref_write(input logic [31:0] a, input logic [31:0] d, input logic [3:0] s);
    for (int i = 0; i < 4; i++) begin
      if (s[i]) begin
        ref_mem[{a[9:2], i[1:0]}] = d[8*i +: 8]; // strobed bytes only
      end
    end
  endtask

  task automatic load_cases();
    int          fd;
    int          n;
    string       line;
    logic [31:0] f0;
    logic [31:0] f1;
    logic [31:0] f2;
    logic [31:0] f3;
    logic [31:0] f4;
    logic [31:0] f5;
    logic [31:0] f6;
    fd = $fopen("tb/bus_cases.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("could not open tb/bus_cases.txt");
    end else begin
      while (!$feof(fd)) begin
        n = $fgets(line, fd);
        if (n > 0 && line.len() > 1 && line[0] != "#") begin
          n = $sscanf(line, "%h %h %h %h %h %h %h", f0, f1, f2, f3, f4, f5, f6);
          if (n == 7 && n_cases < MAX_CASES) begin
            c_port[n_cases]  = f0;
            c_we[n_cases]    = f1;
            c_addr[n_cases]  = f2;
            c_wdata[n_cases] = f3;
            c_wstrb[n_cases] = f4;
            c_rdata[n_cases] = f5;
            c_err[n_cases]   = f6;
            n_cases++;
          end
        end
      end
      $fclose(fd);
      if (n_cases == 0) begin
        errors++;
        $display("no cases found in tb/bus_cases.txt");
      end
      loaded = 1'b1;
    end
  endtask

  function automatic bus_req_t case_req(input int i);
    case_req = '{addr: c_addr[i], wdata: c_wdata[i], wstrb: c_wstrb[i][3:0], we: c_we[i][0]};
  endfunction

  // raise one or both valids together and hold each until its handshake
  task automatic send(input bit do_ifu, input bit do_lsu, input int i_ifu, input int i_lsu);
    bit ifu_left;
    bit lsu_left;
    ifu_left = do_ifu;
    lsu_left = do_lsu;
    @(negedge clk);
    if (do_ifu) begin
      ifu_req = case_req(i_ifu);
      ifu_pending++;
    end
    if (do_lsu) begin
      lsu_req = case_req(i_lsu);
      lsu_pending++;
    end
    ifu_req_valid = do_ifu;
    lsu_req_valid = do_lsu;
    while (ifu_left || lsu_left) begin
      @(posedge clk);
      if (ifu_req_valid && ifu_req_ready) ifu_left = 1'b0;
      if (lsu_req_valid && lsu_req_ready) lsu_left = 1'b0;
      @(negedge clk);
      if (!ifu_left) ifu_req_valid = 1'b0;
      if (!lsu_left) lsu_req_valid = 1'b0;
    end
  endtask

  task automatic check_case(input int i, input bus_rsp_t rsp, input int txn0);
    logic [31:0] a;
    string       pn;
    bit          is_timer;
    a        = c_addr[i];
    pn       = (c_port[i] == 32'd1) ? "lsu_rsp" : "ifu_rsp";
    is_timer = !c_we[i][0] && (a == MTIME_LO_ADDR || a == MTIME_HI_ADDR);
    assert (rsp.err == c_err[i][0])
      else report_mismatch({pn, ".err"}, 32'(rsp.err), c_err[i]);
    if (c_we[i][0]) begin
      if (!a[31]) ref_write(a, c_wdata[i], c_wstrb[i][3:0]);
    end else if (is_timer) begin
      assert (txn_cnt == txn0)
        else begin
          errors++;
          $display("timer read at %0t reached the AXI bus", $time);
        end
      if (a == MTIME_LO_ADDR) begin
        assert (rsp.rdata > last_mtime)
          else begin
            errors++;
            $display("mtime did not advance at %0t: %h after %h", $time, rsp.rdata, last_mtime);
          end
        last_mtime = rsp.rdata;
      end else begin
        assert (rsp.rdata == c_rdata[i])
          else report_mismatch({pn, ".rdata"}, rsp.rdata, c_rdata[i]);
      end
    end else begin
      assert (rsp.rdata == c_rdata[i])
        else report_mismatch({pn, ".rdata"}, rsp.rdata, c_rdata[i]);
      assert (rsp.rdata == (a[31] ? 32'd0 : ref_read(a)))
        else report_mismatch({pn, ".rdata vs reference"}, rsp.rdata,
                             a[31] ? 32'd0 : ref_read(a));
    end
  endtask

  // single beat, incr and id 0 on every transaction
  task automatic check_axi_fields();
    if (arvalid) begin
      assert (ar.len == 8'd0)
        else report_mismatch("ar.len", 32'(ar.len), 32'd0);
      assert (ar.burst == 2'b01)
        else report_mismatch("ar.burst", 32'(ar.burst), 32'd1);
      assert (ar.id == 4'd0)
        else report_mismatch("ar.id", 32'(ar.id), 32'd0);
    end
    if (awvalid) begin
      assert (aw.len == 8'd0)
        else report_mismatch("aw.len", 32'(aw.len), 32'd0);
      assert (aw.burst == 2'b01)
        else report_mismatch("aw.burst", 32'(aw.burst), 32'd1);
      assert (aw.id == 4'd0)
        else report_mismatch("aw.id", 32'(aw.id), 32'd0);
    end
    if (wvalid) begin
      assert (w.last == 1'b1)
        else report_mismatch("w.last", 32'(w.last), 32'd1);
    end
    assert (rready == 1'b1)
      else report_mismatch("rready", 32'(rready), 32'd1);
    assert (bready == 1'b1)
      else report_mismatch("bready", 32'(bready), 32'd1);
  endtask

  // collect responses mid-cycle
  always @(negedge clk) begin
    if (!rst) begin
      check_axi_fields();
      if (ifu_rsp_valid) begin
        if (ifu_pending == 0) begin
          errors++;
          $display("response on the fetch port at %0t without a request", $time);
        end else begin
          ifu_pending--;
          ifu_q.push_back(ifu_rsp);
        end
      end
      if (lsu_rsp_valid) begin
        if (lsu_pending == 0) begin
          errors++;
          $display("response on the load/store port at %0t without a request", $time);
        end else begin
          lsu_pending--;
          lsu_q.push_back(lsu_rsp);
        end
      end
    end
  end

  initial begin
    wait (loaded);
    #((n_cases * 100 + 20) * 40);
    $display("watchdog expired after %0d cycles", n_cases * 100 + 20);
    $display("errors: %0d", errors);
    $display("Test failed");
    $finish;
  end

  initial begin
    int i;
    int txn0;
    void'($urandom(32'h1741));
    rst           = 1'b1;
    ifu_req       = '0;
    lsu_req       = '0;
    ifu_req_valid = 1'b0;
    lsu_req_valid = 1'b0;
    for (int k = 0; k < 1024; k++) begin
      ref_mem[k] = 8'h00;
    end
    load_cases();
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    i = 0;
    while (i < n_cases) begin
      txn0 = txn_cnt;
      if (c_port[i] == 32'd2) begin
        send(1'b1, 1'b1, i, i + 1);
        while (ifu_q.size() == 0 || lsu_q.size() == 0) @(negedge clk);
        check_case(i, ifu_q.pop_front(), txn0);
        check_case(i + 1, lsu_q.pop_front(), txn0);
        i += 2;
      end else if (c_port[i] == 32'd0) begin
        send(1'b1, 1'b0, i, 0);
        while (ifu_q.size() == 0) @(negedge clk);
        check_case(i, ifu_q.pop_front(), txn0);
        i++;
      end else begin
        send(1'b0, 1'b1, 0, i);
        while (lsu_q.size() == 0) @(negedge clk);
        check_case(i, lsu_q.pop_front(), txn0);
        i++;
      end
    end
    repeat (10) @(negedge clk);
    assert (size_errs == 0)
      else begin
        errors++;
        $display("memory model saw %0d writes with awsize not matching the strobe", size_errs);
      end
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- tb/bus_cases.txt
# port(0 ifu, 1 lsu, 2 ifu raised with the next lsu line) we addr wdata wstrb
# exp_rdata exp_err, all hex; mtime low reads only need to grow
1 1 00000010 11223344 f 00000000 0
1 1 00000014 55667788 f 00000000 0
1 1 00000010 0000aa00 2 00000000 0
1 0 00000010 00000000 f 1122aa44 0
1 1 00000014 99880000 c 00000000 0
1 0 00000014 00000000 f 99887788 0
1 1 00000010 ee000000 8 00000000 0
0 0 00000010 00000000 f ee22aa44 0
0 0 00000014 00000000 f 99887788 0
1 0 0200bff8 00000000 f 00000000 0
1 1 00000020 cafef00d f 00000000 0
1 1 00000024 0badbeef f 00000000 0
2 0 00000020 00000000 f cafef00d 0
1 0 00000024 00000000 f 0badbeef 0
0 0 0200bffc 00000000 f 00000000 0
1 0 00000100 00000000 f 00000000 0
1 0 0200bff8 00000000 f 00000000 0
1 1 80000010 deadbeef f 00000000 1
1 0 80000010 00000000 f 00000000 1
1 1 80000014 12345678 1 00000000 1
0 0 80000014 00000000 f 00000000 1

//--- tb.f
source/bus_pkg.sv
source/bus_req_arbiter.sv
source/axi_master_port.sv
source/clint_timer.sv
source/bus_rsp_router.sv
source/core_bus.sv
tb/axi_mem_model.sv
tb/tb_core_bus.sv

//--- Makefile
OBJ_DIR = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -j 0 --top-module tb_core_bus -Mdir $(OBJ_DIR) -f tb.f

run: compile
	./$(OBJ_DIR)/Vtb_core_bus | tee sim.log
	grep -q "^Test passed$$" sim.log

clean:
	rm -rf $(OBJ_DIR) sim.log
